// File: verilog/dcache_defs.svh
/* queue depths, bus and tag widths and cache geometry
   for the data cache memory-side controller */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// request queues
`define STQ_DEPTH 8
`define LDQ_DEPTH 4

// one-hot grant width of the load/store queue
`define LSQSZ 8

// address split: tag | index | byte offset (3 bits)
`define ADDR_W 16
`define IDX_W 5
`define TAG_W 8

// memory transaction tag, zero means no transaction
`define MEM_TAG_W 4

`endif

// File: verilog/dcache_pkg.sv
/* request, memory bus, fill and feedback types shared by the
   data cache memory-side controller */
`include "dcache_defs.svh"

package dcache_pkg;

    typedef enum logic [1:0] {
        byte_sz   = 2'd0,
        half_sz   = 2'd1,
        word_sz   = 2'd2,
        double_sz = 2'd3
    } mem_size_e;

    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_cmd_e;

    // write-back or store miss
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic [63:0]        data;
        mem_size_e          size;
    } store_req_t;

    // load miss, size only matters for the feedback
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        mem_size_e          size;
        logic [`LSQSZ-1:0]  grant;
    } load_req_t;

    typedef struct packed {
        bus_cmd_e           cmd;
        logic [`ADDR_W-1:0] addr;
        mem_size_e          size;
        logic [63:0]        data;
    } mem_req_t;

    typedef struct packed {
        logic [`LSQSZ-1:0] grant;
        logic [31:0]       data;
    } load_result_t;

    typedef struct packed {
        logic [`IDX_W-1:0] idx;
        logic [`TAG_W-1:0] tag;
        logic [63:0]       data;
    } cache_fill_t;

    // load entries freed in one cycle
    typedef logic [2:0] credit_cnt_t;

endpackage

// File: verilog/req_fifo.sv
/* circular FIFO with a type-parameterized payload,
   two pushes (a ahead of b) and one pop per cycle */
`timescale 1ns/10ps

module req_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         push_a,
    input  payload_t                     data_a,
    input  logic                         push_b,
    input  payload_t                     data_b,
    input  logic                         pop,
    output payload_t                     head,
    output logic                         empty,
    output logic [$clog2(depth+1)-1:0]   count
);

    localparam int PW = (depth > 1) ? $clog2(depth) : 1;
    localparam int CW = $clog2(depth + 1);

    payload_t       mem [depth];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [PW-1:0]  wr_ptr_b;
    logic [CW-1:0]  count_next;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // b lands behind a when both push
    assign wr_ptr_b = push_a ? ptr_inc(wr_ptr) : wr_ptr;

    assign count_next = count + CW'(push_a) + CW'(push_b) - CW'(pop);

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= push_b ? ptr_inc(wr_ptr_b) : wr_ptr_b;
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count_next;
        end
    end

    always_ff @(posedge clock) begin
        if (push_a) begin
            mem[wr_ptr] <= data_a;
        end
        if (push_b) begin
            mem[wr_ptr_b] <= data_b;
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);

    // a pop in the same cycle frees the slot for one more push
    a_no_overflow: assert property (@(posedge clock) disable iff (reset)
        int'(count) + int'(push_a) + int'(push_b) <= depth + int'(pop))
        else $error("req_fifo: push while full");

    a_no_underflow: assert property (@(posedge clock) disable iff (reset)
        pop |-> !empty)
        else $error("req_fifo: pop while empty");

endmodule

// File: verilog/store_queue.sv
/* in-order store path for write-backs and store misses,
   one store credit returned per issued entry */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module store_queue (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    wb_valid,
    input  dcache_pkg::store_req_t  wb_req,
    input  logic                    wr_valid,
    input  dcache_pkg::store_req_t  wr_req,
    input  logic                    st_issue,
    output dcache_pkg::store_req_t  st_head,
    output logic                    st_pending,
    output logic                    store_credit
);

    localparam int CW = $clog2(`STQ_DEPTH + 1);

    dcache_pkg::store_req_t  wb_entry;
    logic                    st_empty;
    logic [CW-1:0]           st_count;

    // write-backs always move a whole line
    always_comb begin
        wb_entry      = wb_req;
        wb_entry.size = dcache_pkg::double_sz;
    end

    req_fifo #(
        .payload_t (dcache_pkg::store_req_t),
        .depth     (`STQ_DEPTH)
    ) u_fifo (
        .clock  (clock),
        .reset  (reset),
        .push_a (wb_valid),
        .data_a (wb_entry),
        .push_b (wr_valid),
        .data_b (wr_req),
        .pop    (st_issue),
        .head   (st_head),
        .empty  (st_empty),
        .count  (st_count)
    );

    assign st_pending = !st_empty;

    // the slot is free once memory takes the store
    assign store_credit = st_issue;

    // requester never holds more than STQ_DEPTH credits
    a_store_credit: assert property (@(posedge clock) disable iff (reset)
        int'(st_count) + int'(wb_valid) + int'(wr_valid) <= `STQ_DEPTH + int'(st_issue))
        else $error("store_queue: store sent without a credit");

endmodule

// File: verilog/load_tracker.sv
/* load miss tracker: issue order, in-flight tags matched by search,
   byte extraction, cache fill and squash handling */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module load_tracker (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      rd_valid,
    input  dcache_pkg::load_req_t     rd_req,
    input  logic                      squash,
    input  logic                      ld_issue,
    input  logic [`MEM_TAG_W-1:0]     ld_issue_tag,
    input  logic [`MEM_TAG_W-1:0]     mem_tag,
    input  logic [63:0]               mem_data,
    output dcache_pkg::load_req_t     ld_head,
    output logic                      ld_pending,
    output logic                      feedback_valid,
    output dcache_pkg::load_result_t  feedback,
    output logic                      fill_valid,
    output dcache_pkg::cache_fill_t   fill,
    output dcache_pkg::credit_cnt_t   load_credit
);

    localparam int N  = `LDQ_DEPTH;
    localparam int IW = (N > 1) ? $clog2(N) : 1;
    localparam int CW = $clog2(N + 1);

    typedef logic [IW-1:0] entry_idx_t;

    typedef enum logic [1:0] {
        ent_free,
        ent_waiting,
        ent_in_flight,
        ent_dead
    } entry_state_e;

    entry_state_e             state [N];
    dcache_pkg::load_req_t    entry_req [N];
    logic [`MEM_TAG_W-1:0]    entry_tag [N];

    entry_idx_t               head_idx;
    entry_idx_t               alloc_idx;
    entry_idx_t               hit_idx;
    logic                     alloc_ok;
    logic                     alloc;
    logic [N-1:0]             hit;
    logic                     hit_live;
    logic                     fifo_reset;
    logic                     fifo_empty;
    logic [CW-1:0]            fifo_count;
    logic [CW-1:0]            n_waiting;
    dcache_pkg::credit_cnt_t  freed;
    dcache_pkg::load_req_t    hit_req;
    logic [63:0]              shifted;
    logic [63:0]              size_mask;
    logic [63:0]              masked;

    // lowest free entry
    always_comb begin
        alloc_ok  = 1'b0;
        alloc_idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (state[i] == ent_free) begin
                alloc_ok  = 1'b1;
                alloc_idx = entry_idx_t'(i);
            end
        end
    end

    // a load arriving with squash is cancelled right away
    assign alloc = rd_valid && !squash && alloc_ok;

    // issue order of waiting entries, emptied on squash
    assign fifo_reset = reset || squash;

    req_fifo #(
        .payload_t (entry_idx_t),
        .depth     (N)
    ) u_order (
        .clock  (clock),
        .reset  (fifo_reset),
        .push_a (alloc),
        .data_a (alloc_idx),
        .push_b (1'b0),
        .data_b ('0),
        .pop    (ld_issue),
        .head   (head_idx),
        .empty  (fifo_empty),
        .count  (fifo_count)
    );

    assign ld_head    = entry_req[head_idx];
    assign ld_pending = !fifo_empty;

    // search in-flight and dead entries for the returning tag
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < N; i++) begin
            hit[i] = (mem_tag != '0) && (entry_tag[i] == mem_tag) &&
                     (state[i] == ent_in_flight || state[i] == ent_dead);
            if (hit[i]) begin
                hit_idx = entry_idx_t'(i);
            end
        end
    end

    assign hit_live = (|hit) && (state[hit_idx] == ent_in_flight) && !squash;

    // entries freed this cycle, including a cancelled arrival
    always_comb begin
        freed     = dcache_pkg::credit_cnt_t'(rd_valid && squash);
        n_waiting = '0;
        for (int i = 0; i < N; i++) begin
            if (hit[i]) begin
                freed = freed + 1'b1;
            end
            if (state[i] == ent_waiting) begin
                n_waiting = n_waiting + 1'b1;
                if (squash && !(ld_issue && head_idx == entry_idx_t'(i))) begin
                    freed = freed + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                state[i] <= ent_free;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (hit[i]) begin
                    state[i] <= ent_free;
                end else if (ld_issue && head_idx == entry_idx_t'(i)) begin
                    // issued during a squash, memory still owes the data
                    state[i] <= squash ? ent_dead : ent_in_flight;
                end else if (squash && state[i] == ent_waiting) begin
                    state[i] <= ent_free;
                end else if (squash && state[i] == ent_in_flight) begin
                    state[i] <= ent_dead;
                end
            end
            if (alloc) begin
                state[alloc_idx] <= ent_waiting;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            entry_req[alloc_idx] <= rd_req;
        end
        if (ld_issue) begin
            entry_tag[head_idx] <= ld_issue_tag;
        end
    end

    // pick the addressed bytes out of the returned line
    assign hit_req = entry_req[hit_idx];
    assign shifted = mem_data >> {hit_req.addr[2:0], 3'b000};

    always_comb begin
        case (hit_req.size)
            dcache_pkg::byte_sz: size_mask = 64'h0000_0000_0000_00ff;
            dcache_pkg::half_sz: size_mask = 64'h0000_0000_0000_ffff;
            dcache_pkg::word_sz: size_mask = 64'h0000_0000_ffff_ffff;
            default:             size_mask = '1;
        endcase
    end

    assign masked = shifted & size_mask;

    always_ff @(posedge clock) begin
        if (reset) begin
            feedback_valid <= 1'b0;
            fill_valid     <= 1'b0;
            load_credit    <= '0;
        end else begin
            feedback_valid <= hit_live;
            fill_valid     <= hit_live;
            load_credit    <= freed;
        end
    end

    always_ff @(posedge clock) begin
        if (hit_live) begin
            feedback.grant <= hit_req.grant;
            feedback.data  <= masked[31:0];
            fill.idx       <= hit_req.addr[`IDX_W+2:3];
            fill.tag       <= hit_req.addr[`ADDR_W-1:`ADDR_W-`TAG_W];
            fill.data      <= mem_data;
        end
    end

    a_load_credit: assert property (@(posedge clock) disable iff (reset)
        rd_valid |-> alloc_ok)
        else $error("load_tracker: load sent without a credit");

    a_tag_unique: assert property (@(posedge clock) disable iff (reset)
        $onehot0(hit))
        else $error("load_tracker: tag %0d matches several entries", mem_tag);

    // order queue and entry table must agree on what is waiting
    a_order_in_sync: assert property (@(posedge clock) disable iff (reset)
        fifo_count == n_waiting)
        else $error("load_tracker: issue order out of step with entry table");

endmodule

// File: verilog/mem_issue.sv
/* memory bus issue stage: stores ahead of loads,
   one issue strobe per accepted request */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module mem_issue (
    input  logic                    st_pending,
    input  dcache_pkg::store_req_t  st_head,
    input  logic                    ld_pending,
    input  dcache_pkg::load_req_t   ld_head,
    input  logic [`MEM_TAG_W-1:0]   mem_response,
    output dcache_pkg::mem_req_t    mem_req,
    output logic                    st_issue,
    output logic                    ld_issue,
    output logic [`MEM_TAG_W-1:0]   ld_issue_tag
);

    logic accepted;

    always_comb begin
        mem_req     = '0;
        mem_req.cmd = dcache_pkg::bus_none;
        if (st_pending) begin
            mem_req.cmd  = dcache_pkg::bus_store;
            mem_req.addr = st_head.addr;
            mem_req.size = st_head.size;
            mem_req.data = st_head.data;
        end else if (ld_pending) begin
            // whole line for the fill, the lsq size is applied on return
            mem_req.cmd  = dcache_pkg::bus_load;
            mem_req.addr = ld_head.addr;
            mem_req.size = dcache_pkg::double_sz;
        end
    end

    // zero response is a refusal, request stays on the bus
    assign accepted = (mem_response != '0) && (mem_req.cmd != dcache_pkg::bus_none);

    assign st_issue     = accepted && st_pending;
    assign ld_issue     = accepted && !st_pending;
    assign ld_issue_tag = mem_response;

endmodule

// File: verilog/dcache_mem_ctrl.sv
/* memory-side controller of the data cache: store queue,
   load tracker and memory bus issue stage */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_mem_ctrl (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      squash,
    input  logic                      wb_valid,
    input  dcache_pkg::store_req_t    wb_req,
    input  logic                      wr_valid,
    input  dcache_pkg::store_req_t    wr_req,
    input  logic                      rd_valid,
    input  dcache_pkg::load_req_t     rd_req,
    input  logic [`MEM_TAG_W-1:0]     mem_response,
    input  logic [`MEM_TAG_W-1:0]     mem_tag,
    input  logic [63:0]               mem_data,
    output dcache_pkg::mem_req_t      mem_req,
    output logic                      store_credit,
    output dcache_pkg::credit_cnt_t   load_credit,
    output logic                      feedback_valid,
    output dcache_pkg::load_result_t  feedback,
    output logic                      fill_valid,
    output dcache_pkg::cache_fill_t   fill
);

    dcache_pkg::store_req_t   st_head;
    logic                     st_pending;
    logic                     st_issue;
    dcache_pkg::load_req_t    ld_head;
    logic                     ld_pending;
    logic                     ld_issue;
    logic [`MEM_TAG_W-1:0]    ld_issue_tag;

    store_queue u_store_queue (
        .clock        (clock),
        .reset        (reset),
        .wb_valid     (wb_valid),
        .wb_req       (wb_req),
        .wr_valid     (wr_valid),
        .wr_req       (wr_req),
        .st_issue     (st_issue),
        .st_head      (st_head),
        .st_pending   (st_pending),
        .store_credit (store_credit)
    );

    load_tracker u_load_tracker (
        .clock          (clock),
        .reset          (reset),
        .rd_valid       (rd_valid),
        .rd_req         (rd_req),
        .squash         (squash),
        .ld_issue       (ld_issue),
        .ld_issue_tag   (ld_issue_tag),
        .mem_tag        (mem_tag),
        .mem_data       (mem_data),
        .ld_head        (ld_head),
        .ld_pending     (ld_pending),
        .feedback_valid (feedback_valid),
        .feedback       (feedback),
        .fill_valid     (fill_valid),
        .fill           (fill),
        .load_credit    (load_credit)
    );

    mem_issue u_mem_issue (
        .st_pending   (st_pending),
        .st_head      (st_head),
        .ld_pending   (ld_pending),
        .ld_head      (ld_head),
        .mem_response (mem_response),
        .mem_req      (mem_req),
        .st_issue     (st_issue),
        .ld_issue     (ld_issue),
        .ld_issue_tag (ld_issue_tag)
    );

endmodule

// File: verif/tb_dcache_mem_ctrl.sv
/* clock, reset, memory model with refusals and out-of-order returns,
   stimulus table and compare tasks for the data cache memory-side controller */
`timescale 1ns/10ps
`include "dcache_defs.svh"

module tb_dcache_mem_ctrl;

    localparam int NROWS     = 12;
    localparam int MAX_REF   = 3;
    localparam int MAX_DELAY = 12;
    localparam int PERIOD    = 4;

    // one stimulus row with a refusal count per request
    typedef struct packed {
        logic                    wb_valid;
        dcache_pkg::store_req_t  wb;
        logic [1:0]              wb_refuse;
        logic                    wr_valid;
        dcache_pkg::store_req_t  wr;
        logic [1:0]              wr_refuse;
        logic                    rd_valid;
        dcache_pkg::load_req_t   rd;
        logic [1:0]              rd_refuse;
        logic                    squash;
    } stim_row_t;

    logic                      clock;
    logic                      reset;
    logic                      squash;
    logic                      wb_valid;
    dcache_pkg::store_req_t    wb_req;
    logic                      wr_valid;
    dcache_pkg::store_req_t    wr_req;
    logic                      rd_valid;
    dcache_pkg::load_req_t     rd_req;
    logic [`MEM_TAG_W-1:0]     mem_response;
    logic [`MEM_TAG_W-1:0]     mem_tag;
    logic [63:0]               mem_data;
    dcache_pkg::mem_req_t      mem_req;
    logic                      store_credit;
    dcache_pkg::credit_cnt_t   load_credit;
    logic                      feedback_valid;
    dcache_pkg::load_result_t  feedback;
    logic                      fill_valid;
    dcache_pkg::cache_fill_t   fill;

    stim_row_t                 rows [NROWS];

    // reference model state
    dcache_pkg::store_req_t    st_q [$];
    int                        st_ref_q [$];
    dcache_pkg::load_req_t     ld_q [$];
    int                        ld_ref_q [$];
    dcache_pkg::load_req_t     fl_req [int];
    logic [63:0]               fl_line [int];
    int                        fl_due [int];
    bit                        fl_dead [int];
    logic [7:0]                mem_bytes [logic [`ADDR_W-1:0]];

    int                        cycle;
    int                        st_credits;
    int                        ld_credits;
    int                        next_tag;
    logic                      exp_fb_valid;
    dcache_pkg::load_result_t  exp_fb;
    dcache_pkg::cache_fill_t   exp_fill;
    dcache_pkg::credit_cnt_t   exp_lcredit;

    dcache_mem_ctrl UUT (
        .clock          (clock),
        .reset          (reset),
        .squash         (squash),
        .wb_valid       (wb_valid),
        .wb_req         (wb_req),
        .wr_valid       (wr_valid),
        .wr_req         (wr_req),
        .rd_valid       (rd_valid),
        .rd_req         (rd_req),
        .mem_response   (mem_response),
        .mem_tag        (mem_tag),
        .mem_data       (mem_data),
        .mem_req        (mem_req),
        .store_credit   (store_credit),
        .load_credit    (load_credit),
        .feedback_valid (feedback_valid),
        .feedback       (feedback),
        .fill_valid     (fill_valid),
        .fill           (fill)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        #((NROWS * (MAX_REF + MAX_DELAY) + 300) * PERIOD);
        fail_run("timeout: the run did not finish in time");
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_bus(input string name, input dcache_pkg::mem_req_t got,
                             input dcache_pkg::mem_req_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_feedback(input string name, input dcache_pkg::load_result_t got,
                                  input dcache_pkg::load_result_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_fill(input string name, input dcache_pkg::cache_fill_t got,
                              input dcache_pkg::cache_fill_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_credit(input string name, input dcache_pkg::credit_cnt_t got,
                                input dcache_pkg::credit_cnt_t exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // untouched memory holds a pattern of its own address
    function automatic logic [7:0] byte_at(input logic [`ADDR_W-1:0] a);
        if (mem_bytes.exists(a)) begin
            return mem_bytes[a];
        end
        return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3c;
    endfunction

    function automatic logic [63:0] line_at(input logic [`ADDR_W-1:0] a);
        logic [63:0] line;
        for (int i = 0; i < 8; i++) begin
            line[8*i +: 8] = byte_at({a[`ADDR_W-1:3], 3'b000} + `ADDR_W'(i));
        end
        return line;
    endfunction

    function automatic void write_store(input dcache_pkg::store_req_t s);
        int n;
        n = 1 << s.size;
        for (int i = 0; i < n; i++) begin
            mem_bytes[s.addr + `ADDR_W'(i)] = s.data[8*i +: 8];
        end
    endfunction

    // little-endian byte pick, then size mask, then 32-bit result
    function automatic dcache_pkg::load_result_t extract(input dcache_pkg::load_req_t r,
                                                         input logic [63:0] line);
        logic [63:0]               v;
        dcache_pkg::load_result_t  res;
        v = line >> (8 * r.addr[2:0]);
        case (r.size)
            dcache_pkg::byte_sz: v = v & 64'hff;
            dcache_pkg::half_sz: v = v & 64'hffff;
            dcache_pkg::word_sz: v = v & 64'hffff_ffff;
            default: v = v;
        endcase
        res.grant = r.grant;
        res.data  = v[31:0];
        return res;
    endfunction

    // tags 1 to 15 in rotation that skip loads still out
    function automatic int alloc_tag();
        int t;
        t = next_tag;
        while (fl_req.exists(t)) begin
            t = (t % 15) + 1;
        end
        next_tag = (t % 15) + 1;
        return t;
    endfunction

    function automatic bit model_idle();
        return st_q.size() == 0 && ld_q.size() == 0 && fl_req.num() == 0 &&
               !exp_fb_valid && exp_lcredit == '0;
    endfunction

    task automatic run_cycle(input bit use_row, input stim_row_t r);
        dcache_pkg::mem_req_t    exp_req;
        dcache_pkg::store_req_t  wb_entry;
        int                      freed;
        int                      ret_tag;
        int                      acc_tag;
        bit                      acc_store;
        bit                      acc_load;

        @(negedge clock);
        cycle++;
        check_credit("load_credit", load_credit, exp_lcredit);
        check_bit("feedback_valid", feedback_valid, exp_fb_valid);
        check_bit("fill_valid", fill_valid, exp_fb_valid);
        if (exp_fb_valid) begin
            check_feedback("feedback", feedback, exp_fb);
            check_fill("fill", fill, exp_fill);
        end
        ld_credits += int'(load_credit);

        // stores go first and a load always asks for the whole line
        exp_req   = '0;
        acc_store = 1'b0;
        acc_load  = 1'b0;
        acc_tag   = 0;
        freed     = 0;
        if (st_q.size() > 0) begin
            exp_req.cmd  = dcache_pkg::bus_store;
            exp_req.addr = st_q[0].addr;
            exp_req.size = st_q[0].size;
            exp_req.data = st_q[0].data;
            if (st_ref_q[0] > 0) begin
                st_ref_q[0] = st_ref_q[0] - 1;
            end else begin
                acc_store = 1'b1;
            end
        end else if (ld_q.size() > 0) begin
            exp_req.cmd  = dcache_pkg::bus_load;
            exp_req.addr = ld_q[0].addr;
            exp_req.size = dcache_pkg::double_sz;
            if (ld_ref_q[0] > 0) begin
                ld_ref_q[0] = ld_ref_q[0] - 1;
            end else begin
                acc_load = 1'b1;
            end
        end
        check_bus("mem_req", mem_req, exp_req);
        if (acc_store || acc_load) begin
            acc_tag = alloc_tag();
        end

        ret_tag = 0;
        foreach (fl_due[t]) begin
            if (ret_tag == 0 && fl_due[t] <= cycle) begin
                ret_tag = t;
            end
        end

        mem_response = `MEM_TAG_W'(acc_tag);
        mem_tag      = `MEM_TAG_W'(ret_tag);
        mem_data     = (ret_tag != 0) ? fl_line[ret_tag] : '0;
        squash       = use_row && r.squash;
        wb_valid     = use_row && r.wb_valid;
        wb_req       = r.wb;
        wr_valid     = use_row && r.wr_valid;
        wr_req       = r.wr;
        rd_valid     = use_row && r.rd_valid;
        rd_req       = r.rd;

        if (acc_store) begin
            write_store(st_q[0]);
            void'(st_q.pop_front());
            void'(st_ref_q.pop_front());
        end
        if (ret_tag != 0) begin
            freed++;
            exp_fb_valid = !fl_dead[ret_tag] && !squash;
            if (exp_fb_valid) begin
                exp_fb   = extract(fl_req[ret_tag], fl_line[ret_tag]);
                exp_fill = '{idx:  fl_req[ret_tag].addr[7:3],
                             tag:  fl_req[ret_tag].addr[15:8],
                             data: fl_line[ret_tag]};
            end
            fl_req.delete(ret_tag);
            fl_line.delete(ret_tag);
            fl_due.delete(ret_tag);
            fl_dead.delete(ret_tag);
        end else begin
            exp_fb_valid = 1'b0;
        end
        if (acc_load) begin
            fl_req[acc_tag]  = ld_q[0];
            fl_line[acc_tag] = line_at(ld_q[0].addr);
            fl_due[acc_tag]  = cycle + 1 + int'($urandom % MAX_DELAY);
            fl_dead[acc_tag] = 1'b0;
            void'(ld_q.pop_front());
            void'(ld_ref_q.pop_front());
        end

        // squash frees waiting loads now and kills those in flight
        if (squash) begin
            freed += ld_q.size();
            ld_q.delete();
            ld_ref_q.delete();
            foreach (fl_dead[t]) begin
                fl_dead[t] = 1'b1;
            end
            freed += int'(rd_valid);
        end else if (rd_valid) begin
            ld_q.push_back(r.rd);
            ld_ref_q.push_back(int'(r.rd_refuse));
        end
        if (wb_valid) begin
            wb_entry      = r.wb;
            wb_entry.size = dcache_pkg::double_sz;
            st_q.push_back(wb_entry);
            st_ref_q.push_back(int'(r.wb_refuse));
        end
        if (wr_valid) begin
            st_q.push_back(r.wr);
            st_ref_q.push_back(int'(r.wr_refuse));
        end
        ld_credits -= int'(rd_valid);
        st_credits -= int'(wb_valid) + int'(wr_valid);
        exp_lcredit = dcache_pkg::credit_cnt_t'(freed);

        #1;
        check_bit("store_credit", store_credit, acc_store);
        st_credits += int'(store_credit);
    endtask

    function automatic dcache_pkg::store_req_t st(input logic [`ADDR_W-1:0] a,
                                                  input logic [63:0] d,
                                                  input dcache_pkg::mem_size_e s);
        return '{addr: a, data: d, size: s};
    endfunction

    function automatic dcache_pkg::load_req_t ld(input logic [`ADDR_W-1:0] a,
                                                 input dcache_pkg::mem_size_e s,
                                                 input logic [`LSQSZ-1:0] g);
        return '{addr: a, size: s, grant: g};
    endfunction

    initial begin
        int idx;

        reset        = 1'b1;
        squash       = 1'b0;
        wb_valid     = 1'b0;
        wb_req       = '0;
        wr_valid     = 1'b0;
        wr_req       = '0;
        rd_valid     = 1'b0;
        rd_req       = '0;
        mem_response = '0;
        mem_tag      = '0;
        mem_data     = '0;
        cycle        = 0;
        next_tag     = 1;
        st_credits   = `STQ_DEPTH;
        ld_credits   = `LDQ_DEPTH;
        exp_fb_valid = 1'b0;
        exp_fb       = '0;
        exp_fill     = '0;
        exp_lcredit  = '0;
        void'($urandom(32'hfdbf_f377));

        // the store queue widens this short write-back to a whole line
        rows[0]  = '{wb_valid: 1'b1, wb: st(16'h1200, 64'h0123_4567_89ab_cdef,
                     dcache_pkg::byte_sz), wr_valid: 1'b1,
                     wr: st(16'h1234, 64'hdead_beef, dcache_pkg::word_sz),
                     wr_refuse: 2'd2, default: '0};
        rows[1]  = '{rd_valid: 1'b1, rd: ld(16'h1203, dcache_pkg::byte_sz, 8'h01),
                     rd_refuse: 2'd1, default: '0};
        rows[2]  = '{rd_valid: 1'b1, rd: ld(16'h1236, dcache_pkg::half_sz, 8'h02),
                     default: '0};
        rows[3]  = '{rd_valid: 1'b1, rd: ld(16'h4405, dcache_pkg::word_sz, 8'h04),
                     rd_refuse: 2'd2, default: '0};
        rows[4]  = '{rd_valid: 1'b1, rd: ld(16'h7ff8, dcache_pkg::double_sz, 8'h08),
                     wr_valid: 1'b1, wr: st(16'h2009, 64'h5a, dcache_pkg::byte_sz),
                     wr_refuse: 2'd1, default: '0};
        rows[5]  = '{rd_valid: 1'b1, rd: ld(16'h3010, dcache_pkg::word_sz, 8'h10),
                     rd_refuse: 2'd3, default: '0};
        rows[6]  = '{squash: 1'b1, default: '0};
        rows[7]  = '{rd_valid: 1'b1, rd: ld(16'h2009, dcache_pkg::byte_sz, 8'h20),
                     default: '0};
        rows[8]  = '{wb_valid: 1'b1, wb: st(16'h5a00, 64'hfeed_face_cafe_f00d,
                     dcache_pkg::double_sz), wb_refuse: 2'd1, wr_valid: 1'b1,
                     wr: st(16'h5a04, 64'h1122_3344, dcache_pkg::word_sz), default: '0};
        rows[9]  = '{rd_valid: 1'b1, rd: ld(16'h5a02, dcache_pkg::word_sz, 8'h40),
                     rd_refuse: 2'd1, default: '0};
        rows[10] = '{rd_valid: 1'b1, rd: ld(16'h6611, dcache_pkg::half_sz, 8'h80),
                     squash: 1'b1, default: '0};
        rows[11] = '{rd_valid: 1'b1, rd: ld(16'h5a06, dcache_pkg::half_sz, 8'h01),
                     default: '0};

        repeat (4) @(negedge clock);
        reset = 1'b0;

        // a row goes out only when the requester holds the credits
        idx = 0;
        while (idx < NROWS) begin
            if (ld_credits >= int'(rows[idx].rd_valid) &&
                st_credits >= int'(rows[idx].wb_valid) + int'(rows[idx].wr_valid)) begin
                run_cycle(1'b1, rows[idx]);
                idx++;
            end else begin
                run_cycle(1'b0, '0);
            end
        end
        while (!model_idle()) begin
            run_cycle(1'b0, '0);
        end

        if (ld_credits != `LDQ_DEPTH || st_credits != `STQ_DEPTH) begin
            fail_run($sformatf("credits not all returned: load %0d of %0d, store %0d of %0d",
                               ld_credits, `LDQ_DEPTH, st_credits, `STQ_DEPTH));
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/req_fifo.sv
verilog/store_queue.sv
verilog/load_tracker.sv
verilog/mem_issue.sv
verilog/dcache_mem_ctrl.sv
verif/tb_dcache_mem_ctrl.sv

// File: Bender.yml
package:
  name: dcache_mem_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dcache_pkg.sv
      - verilog/req_fifo.sv
      - verilog/store_queue.sv
      - verilog/load_tracker.sv
      - verilog/mem_issue.sv
      - verilog/dcache_mem_ctrl.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/tb_dcache_mem_ctrl.sv
